/* hw/kernel_pkg.sv */
`default_nettype none

package kernel_pkg;

  typedef logic [14:0] host_addr_t;

  localparam host_addr_t ADDR_DATA0       = 15'h000;  // 8 words, 4-byte steps
  localparam host_addr_t ADDR_AW_PUSH     = 15'h020;
  localparam host_addr_t ADDR_W_PUSH      = 15'h030;
  localparam host_addr_t ADDR_AR_PUSH     = 15'h040;
  localparam host_addr_t ADDR_B_VALID     = 15'h050;
  localparam host_addr_t ADDR_B_POP       = 15'h054;
  localparam host_addr_t ADDR_R_VALID     = 15'h060;
  localparam host_addr_t ADDR_R_POP       = 15'h064;
  localparam host_addr_t ADDR_OCU_RST_ON  = 15'h0c0;
  localparam host_addr_t ADDR_OCU_RST_OFF = 15'h0c4;
  localparam host_addr_t ADDR_CMD_LBA     = 15'h100;
  localparam host_addr_t ADDR_CMD_DPTR    = 15'h104;
  localparam host_addr_t ADDR_CMD_NLB_OPC = 15'h108;
  localparam host_addr_t ADDR_CMD_SUBMIT  = 15'h110;

  typedef logic [63:0]  axi_addr_t;
  typedef logic [127:0] axi_data_t;
  typedef logic [15:0]  axi_strb_t;
  typedef logic [3:0]   axi_id_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_EXOKAY = 2'd1,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } axi_resp_t;

  // size sits above addr, shared by AW and AR
  typedef struct packed {
    logic [2:0] size;
    axi_addr_t  addr;
  } addr_req_t;

  typedef struct packed {
    axi_strb_t strb;
    axi_data_t data;
  } wdata_req_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } bresp_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
    axi_data_t data;
  } rresp_t;

  localparam axi_id_t    K2O_AWID   = 4'd1;
  localparam axi_id_t    K2O_ARID   = 4'd2;
  localparam logic [1:0] BURST_INCR = 2'd1;

endpackage

`default_nettype wire

/* hw/nvme_pkg.sv */
`default_nettype none

package nvme_pkg;

  typedef enum logic [7:0] {
    NVME_OPC_FLUSH = 8'h00,
    NVME_OPC_WRITE = 8'h01,
    NVME_OPC_READ  = 8'h02
  } nvme_opc_e;

  // dw[0] is the lowest dword, so it leaves first on o2k R
  // dw0 cid/opc, dw1 nsid, dw6 dptr, dw10 lba, dw12 nlb
  typedef struct packed {
    logic [15:0][31:0] dw;
  } sq_entry_t;

  localparam logic [31:0] NVME_NSID = 32'd1;

  localparam logic [63:0] SQ_TDBL_ADDR = 64'h5008;  // SQ0 tail doorbell
  localparam logic [63:0] SQ_BASE_ADDR = 64'hb000;

  localparam int unsigned SQ_ENTRY_BYTES = 64;
  localparam int unsigned SQ_BEATS       = 4;  // 128-bit beats per entry

endpackage

`default_nettype wire

/* hw/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int DATA_WIDTH = 8,
  parameter int DEPTH      = 16
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  wvalid,
  input  logic [DATA_WIDTH-1:0] wdata,
  output logic                  wready,
  output logic                  rvalid,
  output logic [DATA_WIDTH-1:0] rdata,
  input  logic                  rready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DATA_WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic                  push;
  logic                  pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    ptr_inc = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign wready = (count != CNT_W'(DEPTH));  // push on full is dropped
  assign rvalid = (count != '0);
  assign rdata  = mem[rd_ptr];  // head falls through
  assign push   = wvalid && wready;
  assign pop    = rvalid && rready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= wdata;
  end

endmodule

`default_nettype wire

/* hw/host_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module host_regs
  import kernel_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  input  logic        host_en,
  input  logic [3:0]  host_we,
  input  host_addr_t  host_addr,
  input  logic [31:0] host_din,
  output logic [31:0] host_dout,
  output logic        ocu_rstn,
  output logic        aw_push,
  output addr_req_t   aw_req,
  output logic        w_push,
  output wdata_req_t  w_req,
  output logic        ar_push,
  output addr_req_t   ar_req,
  output logic        b_pop,
  input  logic        b_valid,
  input  bresp_t      b_head,
  output logic        r_pop,
  input  logic        r_valid,
  input  rresp_t      r_head,
  output logic        lba_wr,
  output logic        dptr_wr,
  output logic        nlb_opc_wr,
  output logic        submit,
  output logic [31:0] field_data
);

  logic         wr_en;
  logic         rd_en;
  logic         in_data;
  logic [2:0]   word_sel;
  logic [255:0] stage;  // staging buffer, word 0 at the bottom
  logic         ocu_rstn_sw;

  assign wr_en    = host_en && (host_we != '0);
  assign rd_en    = host_en && (host_we == '0);
  assign in_data  = (host_addr[14:5] == ADDR_DATA0[14:5]);
  assign word_sel = host_addr[4:2];

  // pops and field writes act on the host write edge itself
  assign b_pop      = wr_en && (host_addr == ADDR_B_POP);
  assign r_pop      = wr_en && (host_addr == ADDR_R_POP);
  assign lba_wr     = wr_en && (host_addr == ADDR_CMD_LBA);
  assign dptr_wr    = wr_en && (host_addr == ADDR_CMD_DPTR);
  assign nlb_opc_wr = wr_en && (host_addr == ADDR_CMD_NLB_OPC);
  assign submit     = wr_en && (host_addr == ADDR_CMD_SUBMIT);
  assign field_data = host_din;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      aw_push     <= 1'b0;
      w_push      <= 1'b0;
      ar_push     <= 1'b0;
      ocu_rstn_sw <= 1'b1;
      ocu_rstn    <= 1'b0;
    end else begin
      aw_push  <= wr_en && (host_addr == ADDR_AW_PUSH);
      w_push   <= wr_en && (host_addr == ADDR_W_PUSH);
      ar_push  <= wr_en && (host_addr == ADDR_AR_PUSH);
      ocu_rstn <= ocu_rstn_sw;  // one cycle behind the sw bit
      if (wr_en && (host_addr == ADDR_OCU_RST_ON)) begin
        ocu_rstn_sw <= 1'b0;
      end else if (wr_en && (host_addr == ADDR_OCU_RST_OFF)) begin
        ocu_rstn_sw <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      if (in_data) begin
        stage[word_sel*32 +: 32] <= host_din;
      end else if (b_pop && b_valid) begin
        stage <= 256'(b_head);
      end else if (r_pop && r_valid) begin
        stage <= 256'(r_head);
      end
      aw_req <= stage[66:0];  // snapshot taken with the push
      w_req  <= stage[143:0];
      ar_req <= stage[66:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      if (in_data) begin
        host_dout <= stage[word_sel*32 +: 32];
      end else if (host_addr == ADDR_B_VALID) begin
        host_dout <= 32'(b_valid);
      end else if (host_addr == ADDR_R_VALID) begin
        host_dout <= 32'(r_valid);
      end else begin
        host_dout <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/nvme_cmd_builder.sv */
`timescale 1ns/1ps
`default_nettype none

module nvme_cmd_builder
  import nvme_pkg::*;
#(
  parameter int SQ_DEPTH = 16
) (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        lba_wr,
  input  logic                        dptr_wr,
  input  logic                        nlb_opc_wr,
  input  logic [31:0]                 field_data,
  input  logic                        submit,
  output logic                        sq_wr,
  output logic [$clog2(SQ_DEPTH)-1:0] sq_wr_idx,
  output sq_entry_t                   sq_wr_entry,
  output logic                        db_push,
  output logic [15:0]                 db_tail
);

  localparam int IDX_W = $clog2(SQ_DEPTH);

  logic [31:0]      lba;
  logic [31:0]      dptr;
  logic [15:0]      nlb;
  nvme_opc_e        opc;
  logic [15:0]      cid;
  logic [IDX_W-1:0] tail;
  logic [IDX_W-1:0] tail_next;
  sq_entry_t        entry;

  assign tail_next = (tail == IDX_W'(SQ_DEPTH - 1)) ? '0 : tail + 1'b1;

  always_comb begin
    entry        = '0;
    entry.dw[0]  = {cid, 8'h00, opc};
    entry.dw[1]  = NVME_NSID;
    entry.dw[6]  = dptr;
    entry.dw[10] = lba;
    entry.dw[12] = {16'h0000, nlb};
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cid     <= '0;
      tail    <= '0;
      sq_wr   <= 1'b0;
      db_push <= 1'b0;
    end else begin
      sq_wr   <= submit;
      db_push <= submit;  // doorbell follows every submit
      if (submit) begin
        cid  <= cid + 1'b1;
        tail <= tail_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lba_wr) lba <= field_data;
    if (dptr_wr) dptr <= field_data;
    if (nlb_opc_wr) begin
      nlb <= field_data[15:0];
      opc <= nvme_opc_e'(field_data[7:0]);  // shares the low byte with nlb
    end
    if (submit) begin
      sq_wr_entry <= entry;
      sq_wr_idx   <= tail;
      db_tail     <= 16'(tail_next);
    end
  end

endmodule

`default_nettype wire

/* hw/nvme_sq.sv */
`timescale 1ns/1ps
`default_nettype none

module nvme_sq
  import kernel_pkg::*;
  import nvme_pkg::*;
#(
  parameter int SQ_DEPTH = 16
) (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        sq_wr,
  input  logic [$clog2(SQ_DEPTH)-1:0] sq_wr_idx,
  input  sq_entry_t                   sq_wr_entry,
  input  logic                        o2k_arvalid,
  output logic                        o2k_arready,
  input  axi_addr_t                   o2k_araddr,
  input  axi_id_t                     o2k_arid,
  output logic                        o2k_rvalid,
  output axi_data_t                   o2k_rdata,
  output axi_id_t                     o2k_rid,
  output logic                        o2k_rlast,
  output axi_resp_t                   o2k_rresp,
  input  logic                        o2k_rready
);

  localparam int IDX_W  = $clog2(SQ_DEPTH);
  localparam int BEAT_W = $clog2(SQ_BEATS);

  typedef enum logic {
    SQ_IDLE,
    SQ_SEND
  } sq_state_e;

  sq_entry_t                  ring [SQ_DEPTH];
  sq_state_e                  state;
  logic [BEAT_W-1:0]          beat;
  axi_data_t [SQ_BEATS-1:0]   cur;  // entry being sent
  axi_addr_t                  offset;
  logic [IDX_W-1:0]           slot;

  assign offset = (o2k_araddr - SQ_BASE_ADDR) / SQ_ENTRY_BYTES;
  assign slot   = IDX_W'(offset % SQ_DEPTH);

  assign o2k_arready = (state == SQ_IDLE);
  assign o2k_rvalid  = (state == SQ_SEND);
  assign o2k_rdata   = cur[beat];
  assign o2k_rlast   = (beat == BEAT_W'(SQ_BEATS - 1));
  assign o2k_rresp   = RESP_OKAY;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= SQ_IDLE;
      beat  <= '0;
    end else begin
      case (state)
        SQ_IDLE: begin
          if (o2k_arvalid) begin  // arlen ignored, always a full entry
            state <= SQ_SEND;
            beat  <= '0;
          end
        end
        SQ_SEND: begin
          if (o2k_rready) begin
            if (o2k_rlast) state <= SQ_IDLE;
            beat <= beat + 1'b1;
          end
        end
        default: state <= SQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sq_wr) ring[sq_wr_idx] <= sq_wr_entry;
    if (o2k_arvalid && o2k_arready) begin
      cur     <= ring[slot];
      o2k_rid <= o2k_arid;
    end
  end

endmodule

`default_nettype wire

/* hw/k2o_master.sv */
`timescale 1ns/1ps
`default_nettype none

module k2o_master
  import kernel_pkg::*;
  import nvme_pkg::*;
#(
  parameter int K2O_FIFO_DEPTH = 16
) (
  input  logic        clk,
  input  logic        rstn,
  input  logic        aw_push,
  input  addr_req_t   aw_req,
  input  logic        w_push,
  input  wdata_req_t  w_req,
  input  logic        ar_push,
  input  addr_req_t   ar_req,
  input  logic        db_push,
  input  logic [15:0] db_tail,
  input  logic        b_pop,
  output logic        b_valid,
  output bresp_t      b_head,
  input  logic        r_pop,
  output logic        r_valid,
  output rresp_t      r_head,
  output axi_addr_t   k2o_awaddr,
  output logic [2:0]  k2o_awsize, k2o_awprot,
  output logic [1:0]  k2o_awburst,
  output logic [3:0]  k2o_awcache, k2o_awqos,
  output axi_id_t     k2o_awid,
  output logic [7:0]  k2o_awlen,
  output logic        k2o_awlock, k2o_awvalid,
  input  logic        k2o_awready,
  output axi_data_t   k2o_wdata,
  output axi_strb_t   k2o_wstrb,
  output logic        k2o_wlast, k2o_wvalid,
  input  logic        k2o_wready,
  output axi_addr_t   k2o_araddr,
  output logic [2:0]  k2o_arsize, k2o_arprot,
  output logic [1:0]  k2o_arburst,
  output logic [3:0]  k2o_arcache, k2o_arqos,
  output axi_id_t     k2o_arid,
  output logic [7:0]  k2o_arlen,
  output logic        k2o_arlock, k2o_arvalid,
  input  logic        k2o_arready,
  input  axi_id_t     k2o_bid,
  input  axi_resp_t   k2o_bresp,
  input  logic        k2o_bvalid,
  output logic        k2o_bready,
  input  axi_id_t     k2o_rid,
  input  axi_resp_t   k2o_rresp,
  input  axi_data_t   k2o_rdata,
  input  logic        k2o_rvalid,
  output logic        k2o_rready
);

  localparam addr_req_t DB_AW = '{size: 3'd2, addr: SQ_TDBL_ADDR};  // 4-byte write

  addr_req_t  aw_in;
  addr_req_t  aw_head;
  addr_req_t  ar_head;
  wdata_req_t w_in;
  wdata_req_t w_head;

  // raw and doorbell pushes come from distinct host writes, never together
  assign aw_in = db_push ? DB_AW : aw_req;
  assign w_in  = db_push ? wdata_req_t'{strb: 16'h000f, data: axi_data_t'(db_tail)} : w_req;

  sync_fifo #(.DATA_WIDTH($bits(addr_req_t)), .DEPTH(K2O_FIFO_DEPTH)) aw_fifo_i (
    .clk, .rstn, .wvalid(aw_push || db_push), .wdata(aw_in), .wready(),
    .rvalid(k2o_awvalid), .rdata(aw_head), .rready(k2o_awready)
  );
  sync_fifo #(.DATA_WIDTH($bits(wdata_req_t)), .DEPTH(K2O_FIFO_DEPTH)) w_fifo_i (
    .clk, .rstn, .wvalid(w_push || db_push), .wdata(w_in), .wready(),
    .rvalid(k2o_wvalid), .rdata(w_head), .rready(k2o_wready)
  );
  sync_fifo #(.DATA_WIDTH($bits(addr_req_t)), .DEPTH(K2O_FIFO_DEPTH)) ar_fifo_i (
    .clk, .rstn, .wvalid(ar_push), .wdata(ar_req), .wready(),
    .rvalid(k2o_arvalid), .rdata(ar_head), .rready(k2o_arready)
  );
  sync_fifo #(.DATA_WIDTH($bits(bresp_t)), .DEPTH(K2O_FIFO_DEPTH)) b_fifo_i (
    .clk, .rstn, .wvalid(k2o_bvalid), .wdata({k2o_bid, k2o_bresp}), .wready(k2o_bready),
    .rvalid(b_valid), .rdata(b_head), .rready(b_pop)
  );
  sync_fifo #(.DATA_WIDTH($bits(rresp_t)), .DEPTH(K2O_FIFO_DEPTH)) r_fifo_i (
    .clk, .rstn, .wvalid(k2o_rvalid), .wdata({k2o_rid, k2o_rresp, k2o_rdata}),
    .wready(k2o_rready), .rvalid(r_valid), .rdata(r_head), .rready(r_pop)
  );

  // single beat, everything else fixed
  assign k2o_awaddr  = aw_head.addr;
  assign k2o_awsize  = aw_head.size;
  assign k2o_awburst = BURST_INCR;
  assign k2o_awcache = '0;
  assign k2o_awid    = K2O_AWID;
  assign k2o_awlen   = '0;
  assign k2o_awlock  = 1'b0;
  assign k2o_awprot  = '0;
  assign k2o_awqos   = '0;
  assign k2o_wdata   = w_head.data;
  assign k2o_wstrb   = w_head.strb;
  assign k2o_wlast   = 1'b1;
  assign k2o_araddr  = ar_head.addr;
  assign k2o_arsize  = ar_head.size;
  assign k2o_arburst = BURST_INCR;
  assign k2o_arcache = '0;
  assign k2o_arid    = K2O_ARID;
  assign k2o_arlen   = '0;
  assign k2o_arlock  = 1'b0;
  assign k2o_arprot  = '0;
  assign k2o_arqos   = '0;

endmodule

`default_nettype wire

/* hw/kernel_top.sv */
`timescale 1ns/1ps
`default_nettype none

module kernel_top
  import kernel_pkg::*;
  import nvme_pkg::*;
#(
  parameter int SQ_DEPTH       = 16,
  parameter int K2O_FIFO_DEPTH = 16
) (
  input  logic        clk,
  input  logic        rstn,
  input  logic        host_en,
  input  logic [3:0]  host_we,
  input  host_addr_t  host_addr,
  input  logic [31:0] host_din,
  output logic [31:0] host_dout,
  output logic        ocu_rstn,
  output axi_addr_t   k2o_awaddr,
  output logic [2:0]  k2o_awsize, k2o_awprot,
  output logic [1:0]  k2o_awburst,
  output logic [3:0]  k2o_awcache, k2o_awqos,
  output axi_id_t     k2o_awid,
  output logic [7:0]  k2o_awlen,
  output logic        k2o_awlock, k2o_awvalid,
  input  logic        k2o_awready,
  output axi_data_t   k2o_wdata,
  output axi_strb_t   k2o_wstrb,
  output logic        k2o_wlast, k2o_wvalid,
  input  logic        k2o_wready,
  output axi_addr_t   k2o_araddr,
  output logic [2:0]  k2o_arsize, k2o_arprot,
  output logic [1:0]  k2o_arburst,
  output logic [3:0]  k2o_arcache, k2o_arqos,
  output axi_id_t     k2o_arid,
  output logic [7:0]  k2o_arlen,
  output logic        k2o_arlock, k2o_arvalid,
  input  logic        k2o_arready,
  input  axi_id_t     k2o_bid,
  input  axi_resp_t   k2o_bresp,
  input  logic        k2o_bvalid,
  output logic        k2o_bready,
  input  axi_id_t     k2o_rid,
  input  axi_resp_t   k2o_rresp,
  input  axi_data_t   k2o_rdata,
  input  logic        k2o_rvalid,
  output logic        k2o_rready,
  input  logic        o2k_arvalid,
  output logic        o2k_arready,
  input  axi_addr_t   o2k_araddr,
  input  axi_id_t     o2k_arid,
  output logic        o2k_rvalid,
  output axi_data_t   o2k_rdata,
  output axi_id_t     o2k_rid,
  output logic        o2k_rlast,
  output axi_resp_t   o2k_rresp,
  input  logic        o2k_rready
);

  logic                        aw_push, w_push, ar_push, b_pop, r_pop, b_valid, r_valid;
  logic                        lba_wr, dptr_wr, nlb_opc_wr, submit, sq_wr, db_push;
  addr_req_t                   aw_req, ar_req;
  wdata_req_t                  w_req;
  bresp_t                      b_head;
  rresp_t                      r_head;
  logic [31:0]                 field_data;
  logic [$clog2(SQ_DEPTH)-1:0] sq_wr_idx;
  sq_entry_t                   sq_wr_entry;
  logic [15:0]                 db_tail;

  host_regs host_regs_i (.*);

  nvme_cmd_builder #(.SQ_DEPTH(SQ_DEPTH)) nvme_cmd_builder_i (.*);

  k2o_master #(.K2O_FIFO_DEPTH(K2O_FIFO_DEPTH)) k2o_master_i (.*);

  nvme_sq #(.SQ_DEPTH(SQ_DEPTH)) nvme_sq_i (.*);

endmodule

`default_nettype wire

/* testbench/tb_kernel.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_kernel
  import kernel_pkg::*;
  import nvme_pkg::*;
();

  localparam int SQ_DEPTH    = 16;
  localparam int FIFO_DEPTH  = 16;
  localparam int N_OPS       = 20;
  localparam int TEST_COUNT  = 6 * N_OPS;
  localparam int WATCHDOG_NS = TEST_COUNT * 200 * 8;
  localparam int WAIT_LIMIT  = 200;  // cycles per drain or fetch

  logic        clk = 1'b0;
  logic        rstn, host_en, ocu_rstn;
  logic [3:0]  host_we;
  host_addr_t  host_addr;
  logic [31:0] host_din, host_dout;
  axi_addr_t   k2o_awaddr, k2o_araddr, o2k_araddr;
  logic [2:0]  k2o_awsize, k2o_awprot, k2o_arsize, k2o_arprot;
  logic [1:0]  k2o_awburst, k2o_arburst;
  logic [3:0]  k2o_awcache, k2o_awqos, k2o_arcache, k2o_arqos;
  axi_id_t     k2o_awid, k2o_arid, k2o_bid, k2o_rid, o2k_arid, o2k_rid;
  logic [7:0]  k2o_awlen, k2o_arlen;
  logic        k2o_awlock, k2o_awvalid, k2o_wlast, k2o_wvalid, k2o_arlock, k2o_arvalid;
  logic        k2o_awready = 1'b0;
  logic        k2o_wready  = 1'b0;
  logic        k2o_arready = 1'b0;
  logic        k2o_bvalid, k2o_bready, k2o_rvalid, k2o_rready;
  logic        o2k_arvalid, o2k_arready, o2k_rvalid, o2k_rlast, o2k_rready;
  axi_data_t   k2o_wdata, k2o_rdata, o2k_rdata;
  axi_strb_t   k2o_wstrb;
  axi_resp_t   k2o_bresp, k2o_rresp, o2k_rresp;

  addr_req_t    exp_aw [$];
  wdata_req_t   exp_w [$];
  addr_req_t    exp_ar [$];
  bresp_t       exp_b [$];
  rresp_t       exp_r [$];
  logic [255:0] exp_stage;
  sq_entry_t    model_ring [SQ_DEPTH];
  logic [15:0]  cid;
  int           tail;
  int           n_sub;

  kernel_top #(.SQ_DEPTH(SQ_DEPTH), .K2O_FIFO_DEPTH(FIFO_DEPTH)) dut_i (.*);

  always #4 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_addr(input string name, input addr_req_t got, input addr_req_t exp);
    if (got !== exp) abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_wdata(input string name, input wdata_req_t got, input wdata_req_t exp);
    if (got !== exp) abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_beat(input string name, input axi_data_t got, input axi_data_t exp);
    if (got !== exp) abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) abort_run($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
  endtask

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic host_write(input host_addr_t addr, input logic [31:0] data);
    host_en   = 1'b1;
    host_we   = 4'hf;
    host_addr = addr;
    host_din  = data;
    tick();
    host_en = 1'b0;
    host_we = 4'h0;
  endtask

  task automatic host_read(input host_addr_t addr, output logic [31:0] data);
    host_en   = 1'b1;
    host_we   = 4'h0;
    host_addr = addr;
    tick();
    host_en = 1'b0;
    data    = host_dout;  // registered on the read edge
  endtask

  task automatic write_stage_word(input int idx, input logic [31:0] data);
    host_write(host_addr_t'(ADDR_DATA0 + 4 * idx), data);
    exp_stage[idx*32 +: 32] = data;
  endtask

  task automatic check_stage();
    logic [31:0] word;
    for (int i = 0; i < 8; i++) begin
      host_read(host_addr_t'(ADDR_DATA0 + 4 * i), word);
      check_word($sformatf("stage word %0d", i), word, exp_stage[i*32 +: 32]);
    end
  endtask

  task automatic raw_push();
    int kind;
    kind = $urandom_range(0, 2);
    for (int i = 0; i < 5; i++) write_stage_word(i, $urandom);
    if (kind == 0) begin
      host_write(ADDR_AW_PUSH, $urandom);
      exp_aw.push_back(addr_req_t'(exp_stage[66:0]));
    end else if (kind == 1) begin
      host_write(ADDR_W_PUSH, $urandom);
      exp_w.push_back(wdata_req_t'(exp_stage[143:0]));
    end else begin
      host_write(ADDR_AR_PUSH, $urandom);
      exp_ar.push_back(addr_req_t'(exp_stage[66:0]));
    end
  endtask

  task automatic wait_k2o_drained();
    int n;
    n = 0;
    while ((exp_aw.size() + exp_w.size() + exp_ar.size()) != 0 && n < WAIT_LIMIT) begin
      tick();
      n++;
    end
    if ((exp_aw.size() + exp_w.size() + exp_ar.size()) != 0)
      abort_run("k2o requests were still outstanding after the drain limit");
  endtask

  // the k2o slave accepts each beat on the edge after valid and ready are seen
  always @(negedge clk) begin
    if (rstn && k2o_awvalid && k2o_awready) begin
      if (exp_aw.size() == 0) abort_run("k2o AW beat arrived with nothing expected");
      else begin
        check_addr("k2o_aw", addr_req_t'({k2o_awsize, k2o_awaddr}), exp_aw.pop_front());
        check_word("k2o_awlen", 32'(k2o_awlen), 32'd0);
        check_word("k2o_awburst", 32'(k2o_awburst), 32'(BURST_INCR));
        check_word("k2o_awid", 32'(k2o_awid), 32'(K2O_AWID));
        check_word("k2o_aw cache qos lock prot",
                   32'({k2o_awcache, k2o_awqos, k2o_awlock, k2o_awprot}), 32'd0);
      end
    end
    if (rstn && k2o_wvalid && k2o_wready) begin
      if (exp_w.size() == 0) abort_run("k2o W beat arrived with nothing expected");
      else begin
        check_wdata("k2o_w", wdata_req_t'({k2o_wstrb, k2o_wdata}), exp_w.pop_front());
        check_bit("k2o_wlast", k2o_wlast, 1'b1);
      end
    end
    if (rstn && k2o_arvalid && k2o_arready) begin
      if (exp_ar.size() == 0) abort_run("k2o AR beat arrived with nothing expected");
      else begin
        check_addr("k2o_ar", addr_req_t'({k2o_arsize, k2o_araddr}), exp_ar.pop_front());
        check_word("k2o_arlen", 32'(k2o_arlen), 32'd0);
        check_word("k2o_arburst", 32'(k2o_arburst), 32'(BURST_INCR));
        check_word("k2o_arid", 32'(k2o_arid), 32'(K2O_ARID));
        check_word("k2o_ar cache qos lock prot",
                   32'({k2o_arcache, k2o_arqos, k2o_arlock, k2o_arprot}), 32'd0);
      end
    end
  end

  always @(posedge clk) begin
    #1;
    k2o_awready = ($urandom_range(0, 3) != 0);
    k2o_wready  = ($urandom_range(0, 3) != 0);
    k2o_arready = ($urandom_range(0, 3) != 0);
  end

  task automatic inject_resp(input logic is_r);
    bresp_t b;
    rresp_t r;
    logic   hs;
    b = '{id: axi_id_t'($urandom_range(0, 15)), resp: axi_resp_t'($urandom_range(0, 3))};
    r = '{id: b.id, resp: b.resp, data: {$urandom, $urandom, $urandom, $urandom}};
    if (is_r) begin
      k2o_rid    = r.id;
      k2o_rresp  = r.resp;
      k2o_rdata  = r.data;
      k2o_rvalid = 1'b1;
    end else begin
      k2o_bid    = b.id;
      k2o_bresp  = b.resp;
      k2o_bvalid = 1'b1;
    end
    do begin
      @(negedge clk);
      hs = is_r ? k2o_rready : k2o_bready;
      tick();
    end while (!hs);
    k2o_bvalid = 1'b0;
    k2o_rvalid = 1'b0;
    if (is_r) exp_r.push_back(r);
    else exp_b.push_back(b);
  endtask

  task automatic check_status(input logic is_r);
    logic [31:0] word;
    host_read(is_r ? ADDR_R_VALID : ADDR_B_VALID, word);
    check_word(is_r ? "r_valid status" : "b_valid status", word,
               32'(is_r ? exp_r.size() != 0 : exp_b.size() != 0));
  endtask

  task automatic pop_resp(input logic is_r);
    bresp_t b;
    rresp_t r;
    host_write(is_r ? ADDR_R_POP : ADDR_B_POP, $urandom);
    if (is_r && exp_r.size() != 0) begin
      r = exp_r.pop_front();
      exp_stage = 256'(r);
    end else if (!is_r && exp_b.size() != 0) begin
      b = exp_b.pop_front();
      exp_stage = 256'(b);
    end
    check_stage();  // an empty pop keeps the old words
  endtask

  task automatic resp_round();
    int nb;
    int nr;
    nb = $urandom_range(1, 4);
    nr = $urandom_range(1, 4);
    repeat (nb) inject_resp(1'b0);
    repeat (nr) inject_resp(1'b1);
    check_status(1'b0);
    check_status(1'b1);
    repeat (nb + 1) pop_resp(1'b0);
    check_status(1'b0);
    repeat (nr + 1) pop_resp(1'b1);
    check_status(1'b1);
  endtask

  task automatic submit_cmd();
    logic [31:0] lba;
    logic [31:0] dptr;
    logic [31:0] nlb_opc;
    sq_entry_t   entry;
    lba     = $urandom;
    dptr    = $urandom;
    nlb_opc = {16'($urandom), 8'($urandom), 8'($urandom_range(0, 2))};  // opcode in low byte
    host_write(ADDR_CMD_LBA, lba);
    host_write(ADDR_CMD_DPTR, dptr);
    host_write(ADDR_CMD_NLB_OPC, nlb_opc);
    host_write(ADDR_CMD_SUBMIT, $urandom);
    entry        = '0;
    entry.dw[0]  = {cid, 8'h00, nlb_opc[7:0]};
    entry.dw[1]  = NVME_NSID;
    entry.dw[6]  = dptr;
    entry.dw[10] = lba;
    entry.dw[12] = {16'h0000, nlb_opc[15:0]};
    model_ring[tail] = entry;
    tail  = (tail + 1) % SQ_DEPTH;
    cid   = cid + 16'd1;
    n_sub = n_sub + 1;
    exp_aw.push_back(addr_req_t'({3'd2, SQ_TDBL_ADDR}));
    exp_w.push_back(wdata_req_t'({16'h000f, axi_data_t'(tail)}));  // new tail in the doorbell
  endtask

  task automatic fetch_entry();
    int           slot;
    int           beat;
    int           n;
    axi_id_t      id;
    logic [511:0] bits;
    logic         hs;
    slot = $urandom_range(0, ((n_sub < SQ_DEPTH) ? n_sub : SQ_DEPTH) - 1);
    id   = axi_id_t'($urandom_range(0, 15));
    bits = model_ring[slot];
    o2k_arid    = id;
    o2k_araddr  = SQ_BASE_ADDR + axi_addr_t'((slot + SQ_DEPTH * $urandom_range(0, 3)) * 64);
    o2k_arvalid = 1'b1;
    do begin
      @(negedge clk);
      hs = o2k_arready;
      tick();
    end while (!hs);
    o2k_arvalid = 1'b0;
    check_bit("o2k_rvalid", o2k_rvalid, 1'b1);  // one cycle after AR
    beat = 0;
    n    = 0;
    while (beat < SQ_BEATS && n < WAIT_LIMIT) begin
      o2k_rready = ($urandom_range(0, 1) != 0);
      @(negedge clk);
      if (o2k_rvalid && o2k_rready) begin
        check_beat($sformatf("o2k_rdata beat %0d", beat), o2k_rdata, bits[beat*128 +: 128]);
        check_word("o2k_rid", 32'(o2k_rid), 32'(id));
        check_bit("o2k_rlast", o2k_rlast, beat == SQ_BEATS - 1);
        check_word("o2k_rresp", 32'(o2k_rresp), 32'(RESP_OKAY));
        beat++;
      end
      tick();
      n++;
    end
    o2k_rready = 1'b0;
    if (beat != SQ_BEATS) abort_run("o2k fetch returned fewer than four beats in time");
    check_bit("o2k_rvalid", o2k_rvalid, 1'b0);
  endtask

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired before the tests completed");
  end

  initial begin
    void'($urandom(32'h4161));
    rstn        = 1'b0;
    host_en     = 1'b0;
    host_we     = 4'h0;
    host_addr   = '0;
    host_din    = '0;
    {k2o_bvalid, k2o_bid} = '0;
    k2o_bresp = RESP_OKAY;
    {k2o_rvalid, k2o_rid, k2o_rdata} = '0;
    k2o_rresp = RESP_OKAY;
    {o2k_arvalid, o2k_araddr, o2k_arid, o2k_rready} = '0;
    cid   = '0;
    tail  = 0;
    n_sub = 0;
    repeat (5) @(posedge clk);
    #1;
    check_bit("ocu_rstn", ocu_rstn, 1'b0);
    check_bit("k2o_awvalid", k2o_awvalid, 1'b0);
    check_bit("k2o_wvalid", k2o_wvalid, 1'b0);
    check_bit("k2o_arvalid", k2o_arvalid, 1'b0);
    check_bit("o2k_rvalid", o2k_rvalid, 1'b0);
    repeat (5) @(posedge clk);
    #1;
    rstn = 1'b1;
    tick();
    check_bit("ocu_rstn", ocu_rstn, 1'b1);

    repeat (N_OPS) begin
      for (int i = 0; i < 8; i++) write_stage_word(i, $urandom);
      check_stage();
    end
    repeat (N_OPS) raw_push();
    wait_k2o_drained();
    repeat (N_OPS / 4) resp_round();
    repeat (N_OPS) submit_cmd();
    wait_k2o_drained();
    repeat (N_OPS) fetch_entry();

    host_write(ADDR_OCU_RST_ON, $urandom);
    repeat (2) tick();
    check_bit("ocu_rstn", ocu_rstn, 1'b0);
    host_write(ADDR_OCU_RST_OFF, $urandom);
    repeat (2) tick();
    check_bit("ocu_rstn", ocu_rstn, 1'b1);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
hw/kernel_pkg.sv
hw/nvme_pkg.sv
hw/sync_fifo.sv
hw/host_regs.sv
hw/nvme_cmd_builder.sv
hw/nvme_sq.sv
hw/k2o_master.sv
hw/kernel_top.sv
testbench/tb_kernel.sv

/* Makefile */
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/Vtb_kernel: list.f hw/*.sv testbench/*.sv
	verilator --binary --timing -Wno-fatal -f list.f --top-module tb_kernel -Mdir obj_dir

run: obj_dir/Vtb_kernel
	./obj_dir/Vtb_kernel 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module kernel_top

clean:
	rm -rf obj_dir $(LOG)
